// ==== hdl/sata_phy_defs.svh ====
// SATA PHY shared constants
`ifndef SATA_PHY_DEFS_SVH
`define SATA_PHY_DEFS_SVH

//////////////////////////////
// Primitive words
//////////////////////////////

// ALIGN primitive with K28.5 in lane 0
`define SATA_ALIGN_WORD 32'h7B4A_4ABC
// SYNC primitive with K28.3 in lane 0
`define SATA_SYNC_WORD 32'hB5B5_957C
// D10.2 filler sent while waiting for ALIGN
`define SATA_D102_WORD 32'h4A4A_4A4A
// K28.3 character in the low byte
`define SATA_K283_BYTE 8'h7C
// Only lane 0 carries a K character
`define SATA_K_LANE0 4'b0001

//////////////////////////////
// Timers
//////////////////////////////

// 10 ms at 75 MHz
`define SATA1_RETRY_CYCLES 750000
// 873.8 us at 75 MHz
`define SATA1_ALIGN_WAIT_CYCLES 65535
`define SATA_TIMER_WIDTH 32
// Consecutive K28.3 words before ready
`define SATA_ALIGN_RUN 3

`endif

// ==== hdl/sata_oob_pkg.sv ====
// SATA OOB sequence types
package sata_oob_pkg;

  // Host OOB states in protocol order
  typedef enum logic [3:0] {
    HP1_RESET             = 4'd0,
    HP2_AWAIT_COMINIT     = 4'd1,
    HP2B_AWAIT_NO_COMINIT = 4'd2,
    HP3_CALIBRATE         = 4'd3,
    HP4_COMWAKE           = 4'd4,
    HP5_AWAIT_COMWAKE     = 4'd5,
    HP5B_AWAIT_NO_COMWAKE = 4'd6,
    HP6_AWAIT_ALIGN       = 4'd7,
    HP7_SEND_ALIGN        = 4'd8,
    HP8_READY             = 4'd9
  } oob_state_e;

  // Transceiver COM burst selection
  typedef enum logic {COM_RESET = 1'b0, COM_WAKE = 1'b1} com_type_e;

endpackage

// ==== hdl/sata_prim_pkg.sv ====
// SATA primitive and word types
package sata_prim_pkg;

  // One 32-bit transceiver word
  typedef logic [31:0] dword_t;

  // Per-byte K character flags
  typedef logic [3:0] charisk_t;

  // Primitive selected for transmit
  typedef enum logic [1:0] {
    PRIM_NONE  = 2'd0,
    PRIM_D102  = 2'd1,
    PRIM_ALIGN = 2'd2,
    PRIM_SYNC  = 2'd3
  } prim_e;

endpackage

// ==== hdl/oob_if.sv ====
// OOB sequencer status interface
`timescale 1ns/1ps

interface oob_if;

  // Current sequencer state
  sata_oob_pkg::oob_state_e state;
  // COM burst reported sent by the transceiver
  logic com_done;
  // Timer expiry flags
  logic retry_expired;
  logic align_expired;
  // Receive primitive flags
  logic align_det;
  logic align_run_done;

  // Sequencer owns the state and reads every flag
  modport seq (
    output state,
    input  com_done,
    input  retry_expired,
    input  align_expired,
    input  align_det,
    input  align_run_done
  );

  modport com (input state, output com_done);
  modport timer (input state, output retry_expired, output align_expired);
  modport tx (input state);
  modport rx (input state, output align_det, output align_run_done);

endinterface

// ==== hdl/oob_seq.sv ====
// OOB host bring-up sequencer
`timescale 1ns/1ps

module oob_seq (
  input  logic clk_phy,
  input  logic rst_n,
  input  logic gt_rst_done_i,
  input  logic cominit_i,
  input  logic comwake_i,
  input  logic rx_elec_idle_i,
  oob_if.seq   ifc,
  output logic link_up_o
);

  sata_oob_pkg::oob_state_e state_q;
  sata_oob_pkg::oob_state_e state_d;

  assign ifc.state = state_q;

  //////////////////////////////
  // State register
  //////////////////////////////

  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      state_q <= sata_oob_pkg::HP1_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Leave once COMRESET is out and COMINIT is quiet
      sata_oob_pkg::HP1_RESET: begin
        if (gt_rst_done_i && ifc.com_done && !cominit_i) begin
          state_d = sata_oob_pkg::HP2_AWAIT_COMINIT;
        end
      end
      // No COMINIT in time sends COMRESET again
      sata_oob_pkg::HP2_AWAIT_COMINIT: begin
        if (cominit_i) begin
          state_d = sata_oob_pkg::HP2B_AWAIT_NO_COMINIT;
        end else if (ifc.retry_expired) begin
          state_d = sata_oob_pkg::HP1_RESET;
        end
      end
      sata_oob_pkg::HP2B_AWAIT_NO_COMINIT: begin
        if (!cominit_i) begin
          state_d = sata_oob_pkg::HP3_CALIBRATE;
        end
      end
      // Single cycle, no calibration done here
      sata_oob_pkg::HP3_CALIBRATE: begin
        state_d = sata_oob_pkg::HP4_COMWAKE;
      end
      sata_oob_pkg::HP4_COMWAKE: begin
        if (ifc.com_done) begin
          state_d = sata_oob_pkg::HP5_AWAIT_COMWAKE;
        end
      end
      sata_oob_pkg::HP5_AWAIT_COMWAKE: begin
        if (comwake_i) begin
          state_d = sata_oob_pkg::HP5B_AWAIT_NO_COMWAKE;
        end else if (ifc.retry_expired) begin
          state_d = sata_oob_pkg::HP1_RESET;
        end
      end
      sata_oob_pkg::HP5B_AWAIT_NO_COMWAKE: begin
        if (!comwake_i) begin
          state_d = sata_oob_pkg::HP6_AWAIT_ALIGN;
        end
      end
      // ALIGN wins over a timeout in the same cycle
      sata_oob_pkg::HP6_AWAIT_ALIGN: begin
        if (ifc.align_det) begin
          state_d = sata_oob_pkg::HP7_SEND_ALIGN;
        end else if (ifc.align_expired) begin
          state_d = sata_oob_pkg::HP1_RESET;
        end
      end
      sata_oob_pkg::HP7_SEND_ALIGN: begin
        if (ifc.align_run_done) begin
          state_d = sata_oob_pkg::HP8_READY;
        end
      end
      // Receive idle means the link is lost
      sata_oob_pkg::HP8_READY: begin
        if (rx_elec_idle_i) begin
          state_d = sata_oob_pkg::HP1_RESET;
        end
      end
      default: begin
        state_d = sata_oob_pkg::HP1_RESET;
      end
    endcase
  end

  // Link up one cycle behind ready
  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      link_up_o <= 1'b0;
    end else begin
      link_up_o <= (state_q == sata_oob_pkg::HP8_READY);
    end
  end

  // Encoding stays inside the ten states
  a_state_legal: assert property (@(posedge clk_phy) disable iff (!rst_n)
    state_q <= sata_oob_pkg::HP8_READY);

  // Link up only ever follows a ready cycle
  a_link_up_ready: assert property (@(posedge clk_phy) disable iff (!rst_n)
    link_up_o |-> $past(state_q) == sata_oob_pkg::HP8_READY);

endmodule

// ==== hdl/com_launcher.sv ====
// COM burst start and completion
`timescale 1ns/1ps

module com_launcher (
  input  logic                    clk_phy,
  input  logic                    rst_n,
  input  logic                    gt_rst_done_i,
  input  logic                    com_sent_i,
  oob_if.com                      ifc,
  output logic                    com_strt_o,
  output sata_oob_pkg::com_type_e com_type_o
);

  logic com_req;
  logic com_req_q;
  logic com_req_d1;
  logic com_done_q;
  logic in_com_state;

  // COMRESET needs the transceiver out of reset
  assign com_req = ((ifc.state == sata_oob_pkg::HP1_RESET) && gt_rst_done_i) ||
                   (ifc.state == sata_oob_pkg::HP4_COMWAKE);
  assign in_com_state = (ifc.state == sata_oob_pkg::HP1_RESET) ||
                        (ifc.state == sata_oob_pkg::HP4_COMWAKE);
  assign ifc.com_done = com_done_q;

  //////////////////////////////
  // Start pulse
  //////////////////////////////

  // Rising edge of the request gives one pulse per entry
  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      com_req_q  <= 1'b0;
      com_req_d1 <= 1'b0;
      com_strt_o <= 1'b0;
    end else begin
      com_req_q  <= com_req;
      com_req_d1 <= com_req_q;
      com_strt_o <= com_req_q && !com_req_d1;
    end
  end

  // Type settles a cycle ahead of the pulse and holds after
  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      com_type_o <= sata_oob_pkg::COM_RESET;
    end else if ((ifc.state == sata_oob_pkg::HP1_RESET) && gt_rst_done_i) begin
      com_type_o <= sata_oob_pkg::COM_RESET;
    end else if (ifc.state == sata_oob_pkg::HP4_COMWAKE) begin
      com_type_o <= sata_oob_pkg::COM_WAKE;
    end
  end

  // COM sent report latched only while a burst is pending
  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      com_done_q <= 1'b0;
    end else if (!in_com_state) begin
      com_done_q <= 1'b0;
    end else if (com_sent_i) begin
      com_done_q <= 1'b1;
    end
  end

  a_strt_single: assert property (@(posedge clk_phy) disable iff (!rst_n)
    com_strt_o |=> !com_strt_o);

endmodule

// ==== hdl/oob_timers.sv ====
// OOB retry and ALIGN wait timers
`timescale 1ns/1ps
`include "sata_phy_defs.svh"

module oob_timers #(
  parameter logic [`SATA_TIMER_WIDTH-1:0] RETRY_CYCLES      = `SATA1_RETRY_CYCLES,
  parameter logic [`SATA_TIMER_WIDTH-1:0] ALIGN_WAIT_CYCLES = `SATA1_ALIGN_WAIT_CYCLES
) (
  input logic  clk_phy,
  input logic  rst_n,
  oob_if.timer ifc
);

  logic [`SATA_TIMER_WIDTH-1:0] retry_cnt;
  logic [`SATA_TIMER_WIDTH-1:0] align_cnt;
  logic                         retry_zero;
  logic                         align_zero;

  assign retry_zero        = (retry_cnt == '0);
  assign align_zero        = (align_cnt == '0);
  assign ifc.retry_expired = retry_zero;
  assign ifc.align_expired = align_zero;

  // Reloaded after COMINIT so COMWAKE gets a full window
  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      retry_cnt <= RETRY_CYCLES;
    end else begin
      case (ifc.state)
        sata_oob_pkg::HP1_RESET,
        sata_oob_pkg::HP2B_AWAIT_NO_COMINIT: retry_cnt <= RETRY_CYCLES;
        sata_oob_pkg::HP2_AWAIT_COMINIT,
        sata_oob_pkg::HP5_AWAIT_COMWAKE: begin
          if (!retry_zero) begin
            retry_cnt <= retry_cnt - 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      align_cnt <= ALIGN_WAIT_CYCLES;
    end else if (ifc.state == sata_oob_pkg::HP1_RESET) begin
      align_cnt <= ALIGN_WAIT_CYCLES;
    end else if ((ifc.state == sata_oob_pkg::HP6_AWAIT_ALIGN) && !align_zero) begin
      align_cnt <= align_cnt - 1'b1;
    end
  end

  // Zero count in a wait state is always acted on next cycle
  a_retry_leave: assert property (@(posedge clk_phy) disable iff (!rst_n)
    retry_zero && (ifc.state inside {sata_oob_pkg::HP2_AWAIT_COMINIT,
                                     sata_oob_pkg::HP5_AWAIT_COMWAKE})
    |=> !(ifc.state inside {sata_oob_pkg::HP2_AWAIT_COMINIT,
                            sata_oob_pkg::HP5_AWAIT_COMWAKE}));

  a_align_leave: assert property (@(posedge clk_phy) disable iff (!rst_n)
    align_zero && (ifc.state == sata_oob_pkg::HP6_AWAIT_ALIGN)
    |=> ifc.state != sata_oob_pkg::HP6_AWAIT_ALIGN);

endmodule

// ==== hdl/tx_prim_gen.sv ====
// Transmit primitive generator
`timescale 1ns/1ps
`include "sata_phy_defs.svh"

module tx_prim_gen (
  input  logic                    clk_phy,
  input  logic                    rst_n,
  oob_if.tx                       ifc,
  output sata_prim_pkg::dword_t   tx_data_o,
  output sata_prim_pkg::charisk_t tx_charisk_o,
  output logic                    tx_elec_idle_o
);

  sata_prim_pkg::prim_e prim;

  // Only the three data states drive a primitive
  always_comb begin
    case (ifc.state)
      sata_oob_pkg::HP6_AWAIT_ALIGN: prim = sata_prim_pkg::PRIM_D102;
      sata_oob_pkg::HP7_SEND_ALIGN:  prim = sata_prim_pkg::PRIM_ALIGN;
      sata_oob_pkg::HP8_READY:       prim = sata_prim_pkg::PRIM_SYNC;
      default:                       prim = sata_prim_pkg::PRIM_NONE;
    endcase
  end

  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      tx_data_o    <= '0;
      tx_charisk_o <= '0;
    end else begin
      case (prim)
        sata_prim_pkg::PRIM_D102: begin
          tx_data_o    <= `SATA_D102_WORD;
          tx_charisk_o <= '0;
        end
        sata_prim_pkg::PRIM_ALIGN: begin
          tx_data_o    <= `SATA_ALIGN_WORD;
          tx_charisk_o <= `SATA_K_LANE0;
        end
        sata_prim_pkg::PRIM_SYNC: begin
          tx_data_o    <= `SATA_SYNC_WORD;
          tx_charisk_o <= `SATA_K_LANE0;
        end
        default: begin
          tx_data_o    <= '0;
          tx_charisk_o <= '0;
        end
      endcase
    end
  end

  // HP5B exits to HP6 on COMWAKE release, so idle ends with a primitive
  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      tx_elec_idle_o <= 1'b0;
    end else begin
      tx_elec_idle_o <= (prim == sata_prim_pkg::PRIM_NONE);
    end
  end

endmodule

// ==== hdl/rx_prim_detect.sv ====
// Receive ALIGN and K28.3 detection
`timescale 1ns/1ps
`include "sata_phy_defs.svh"

module rx_prim_detect (
  input logic                  clk_phy,
  input logic                  rst_n,
  input sata_prim_pkg::dword_t rx_data_i,
  oob_if.rx                    ifc
);

  localparam int RUN_W = $clog2(`SATA_ALIGN_RUN + 1);

  logic [RUN_W-1:0] run_cnt;
  logic             run_done;

  // Full word compare against ALIGN
  assign ifc.align_det      = (rx_data_i == `SATA_ALIGN_WORD);
  assign run_done           = (run_cnt == RUN_W'(`SATA_ALIGN_RUN));
  assign ifc.align_run_done = run_done;

  // Run of K28.3 low bytes while sending ALIGN
  // Any other word or state restarts the run
  always_ff @(posedge clk_phy) begin
    if (!rst_n) begin
      run_cnt <= '0;
    end else if (ifc.state != sata_oob_pkg::HP7_SEND_ALIGN) begin
      run_cnt <= '0;
    end else if (rx_data_i[7:0] != `SATA_K283_BYTE) begin
      run_cnt <= '0;
    end else if (!run_done) begin
      run_cnt <= run_cnt + 1'b1;
    end
  end

endmodule

// ==== hdl/sata_phy_host_ctrl.sv ====
// SATA PHY host OOB control
`timescale 1ns/1ps
`include "sata_phy_defs.svh"

module sata_phy_host_ctrl #(
  parameter logic [`SATA_TIMER_WIDTH-1:0] RETRY_CYCLES      = `SATA1_RETRY_CYCLES,
  parameter logic [`SATA_TIMER_WIDTH-1:0] ALIGN_WAIT_CYCLES = `SATA1_ALIGN_WAIT_CYCLES
) (
  input  logic        clk_phy,
  input  logic        rst_n,
  input  logic        gt_rst_done_i,
  input  logic [31:0] gt_rx_data_i,
  // Bit 2 COMINIT, bit 1 COMWAKE, bit 0 COM sent
  input  logic [2:0]  gt_rx_status_i,
  input  logic        gt_rx_elec_idle_i,
  output logic        link_up_o,
  output logic [31:0] gt_tx_data_o,
  output logic [3:0]  gt_tx_charisk_o,
  output logic        gt_tx_com_strt_o,
  output logic        gt_tx_com_type_o,
  output logic        gt_tx_elec_idle_o
);

  oob_if u_oob_if ();

  oob_seq u_oob_seq (
    .clk_phy        (clk_phy),
    .rst_n          (rst_n),
    .gt_rst_done_i  (gt_rst_done_i),
    .cominit_i      (gt_rx_status_i[2]),
    .comwake_i      (gt_rx_status_i[1]),
    .rx_elec_idle_i (gt_rx_elec_idle_i),
    .ifc            (u_oob_if.seq),
    .link_up_o      (link_up_o)
  );

  com_launcher u_com_launcher (
    .clk_phy       (clk_phy),
    .rst_n         (rst_n),
    .gt_rst_done_i (gt_rst_done_i),
    .com_sent_i    (gt_rx_status_i[0]),
    .ifc           (u_oob_if.com),
    .com_strt_o    (gt_tx_com_strt_o),
    .com_type_o    (gt_tx_com_type_o)
  );

  oob_timers #(
    .RETRY_CYCLES      (RETRY_CYCLES),
    .ALIGN_WAIT_CYCLES (ALIGN_WAIT_CYCLES)
  ) u_oob_timers (
    .clk_phy (clk_phy),
    .rst_n   (rst_n),
    .ifc     (u_oob_if.timer)
  );

  tx_prim_gen u_tx_prim_gen (
    .clk_phy        (clk_phy),
    .rst_n          (rst_n),
    .ifc            (u_oob_if.tx),
    .tx_data_o      (gt_tx_data_o),
    .tx_charisk_o   (gt_tx_charisk_o),
    .tx_elec_idle_o (gt_tx_elec_idle_o)
  );

  rx_prim_detect u_rx_prim_detect (
    .clk_phy   (clk_phy),
    .rst_n     (rst_n),
    .rx_data_i (gt_rx_data_i),
    .ifc       (u_oob_if.rx)
  );

endmodule

// ==== dv/sata_dev_model.sv ====
// SATA device OOB responder
`timescale 1ns/1ps
`include "sata_phy_defs.svh"

module sata_dev_model (
  input  logic        clk_i,
  input  logic        com_strt_i,
  input  logic        com_type_i,
  input  logic        no_cominit_i,
  input  logic        no_align_i,
  input  logic        break_run_i,
  output logic [2:0]  rx_status_o,
  output logic [31:0] rx_data_o
);

  integer seed;
  logic   again;
  logic   ty;

  function automatic int rand_delay();
    return 2 + ($unsigned($random(seed)) % 9);
  endfunction

  task automatic pulse_bit(input int b, input int width);
    rx_status_o[b] <= 1'b1;
    repeat (width) @(posedge clk_i);
    rx_status_o[b] <= 1'b0;
  endtask

  // One COM burst answered; stays in the word stream until the next start
  task automatic serve(input logic ty_in, output logic more, output logic ty_next);
    int          run;
    logic [31:0] w;
    more = 1'b0;
    ty_next = ty_in;
    run = 0;
    repeat (rand_delay()) @(posedge clk_i);
    pulse_bit(0, 1);
    if (ty_in == 1'b0) begin
      if (!no_cominit_i) begin
        repeat (rand_delay()) @(posedge clk_i);
        pulse_bit(2, rand_delay());
      end
    end else begin
      repeat (rand_delay()) @(posedge clk_i);
      pulse_bit(1, rand_delay());
      // Filler words before ALIGN
      repeat (rand_delay()) begin
        @(posedge clk_i);
        rx_data_o <= {$random(seed)} & 32'hFFFF_FF00;
      end
      if (!no_align_i) begin
        repeat (2) begin
          @(posedge clk_i);
          rx_data_o <= `SATA_ALIGN_WORD;
        end
      end
      while (!more) begin
        @(posedge clk_i);
        if (com_strt_i) begin
          more = 1'b1;
          ty_next = com_type_i;
        end else begin
          w = $random(seed);
          if (no_align_i) begin
            w[7:0] = 8'h00;
          end else if (break_run_i && run == 2) begin
            w[7:0] = 8'h00;
          end else begin
            w[7:0] = `SATA_K283_BYTE;
          end
          run++;
          rx_data_o <= w;
        end
      end
    end
  endtask

  initial begin
    seed = 92;
    rx_status_o = 3'b000;
    rx_data_o = 32'h0;
    forever begin
      @(posedge clk_i);
      if (com_strt_i) begin
        ty = com_type_i;
        again = 1'b1;
        while (again) begin
          serve(ty, again, ty);
        end
      end
    end
  end

endmodule

// ==== dv/sata_phy_host_ctrl_tb.sv ====
// SATA host OOB testbench
`timescale 1ns/1ps
`include "sata_phy_defs.svh"

module sata_phy_host_ctrl_tb;

  localparam int RETRY = 64;
  localparam int ALIGN_WAIT = 48;

  logic        clk_phy = 1'b0;
  logic        rst_n;
  logic        gt_rst_done_i;
  logic [31:0] gt_rx_data_i;
  logic [2:0]  gt_rx_status_i;
  logic        gt_rx_elec_idle_i;
  logic        link_up_o;
  logic [31:0] gt_tx_data_o;
  logic [3:0]  gt_tx_charisk_o;
  logic        gt_tx_com_strt_o;
  logic        gt_tx_com_type_o;
  logic        gt_tx_elec_idle_o;
  logic        no_cominit = 1'b0;
  logic        no_align = 1'b0;
  logic        break_run = 1'b0;
  logic        expect_down = 1'b0;
  logic        in_reset = 1'b1;
  logic        link_q = 1'b0;
  integer      seed = 92;
  int          errors = 0;
  int          rx_run = 0;

  always #2 clk_phy = ~clk_phy;

  sata_phy_host_ctrl #(.RETRY_CYCLES(RETRY), .ALIGN_WAIT_CYCLES(ALIGN_WAIT)) DUT (
    .clk_phy           (clk_phy),
    .rst_n             (rst_n),
    .gt_rst_done_i     (gt_rst_done_i),
    .gt_rx_data_i      (gt_rx_data_i),
    .gt_rx_status_i    (gt_rx_status_i),
    .gt_rx_elec_idle_i (gt_rx_elec_idle_i),
    .link_up_o         (link_up_o),
    .gt_tx_data_o      (gt_tx_data_o),
    .gt_tx_charisk_o   (gt_tx_charisk_o),
    .gt_tx_com_strt_o  (gt_tx_com_strt_o),
    .gt_tx_com_type_o  (gt_tx_com_type_o),
    .gt_tx_elec_idle_o (gt_tx_elec_idle_o)
  );

  sata_dev_model u_dev (
    .clk_i        (clk_phy),
    .com_strt_i   (gt_tx_com_strt_o),
    .com_type_i   (gt_tx_com_type_o),
    .no_cominit_i (no_cominit),
    .no_align_i   (no_align),
    .break_run_i  (break_run),
    .rx_status_o  (gt_rx_status_i),
    .rx_data_o    (gt_rx_data_i)
  );

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  ////////////////////////////////
  // Output model checked at negedge
  ////////////////////////////////

  // Run of received K28.3 words as the DUT sees them
  always @(posedge clk_phy) begin
    rx_run <= (gt_rx_data_i[7:0] == `SATA_K283_BYTE) ? rx_run + 1 : 0;
  end

  always @(negedge clk_phy) begin
    if (in_reset) begin
      // Nothing to predict before the first reset edge
    end else if (link_up_o) begin
      compare("ready_data", `SATA_SYNC_WORD, gt_tx_data_o);
      compare("ready_charisk", `SATA_K_LANE0, gt_tx_charisk_o);
      compare("ready_idle", 0, gt_tx_elec_idle_o);
      compare("link_held_down", 0, expect_down);
      if (!link_q) begin
        compare("k283_run_before_up", 1, rx_run >= `SATA_ALIGN_RUN);
      end
    end else if (gt_tx_elec_idle_o) begin
      compare("idle_data", 0, gt_tx_data_o);
      compare("idle_charisk", 0, gt_tx_charisk_o);
    end else if (gt_tx_data_o == `SATA_ALIGN_WORD) begin
      compare("align_charisk", `SATA_K_LANE0, gt_tx_charisk_o);
    end else begin
      compare("wait_align_data", `SATA_D102_WORD, gt_tx_data_o);
      compare("wait_align_charisk", 0, gt_tx_charisk_o);
    end
    link_q <= link_up_o;
  end

  function automatic logic cond_met(input int code);
    case (code)
      0: return link_up_o;
      1: return !link_up_o;
      2: return !gt_tx_elec_idle_o;
      default: return gt_tx_data_o == `SATA_ALIGN_WORD;
    endcase
  endfunction

  task automatic wait_cond(input int code, input int limit, input string what);
    int i;
    for (i = 0; i < limit && !cond_met(code); i++) begin
      @(negedge clk_phy);
    end
    if (!cond_met(code)) begin
      $display("Timeout: %s did not happen", what);
      errors++;
      finish_run();
    end
  endtask

  task automatic wait_strt(input string what, input int limit, input logic exp_ty,
                           output int cycles);
    cycles = 0;
    @(negedge clk_phy);
    while (!gt_tx_com_strt_o && cycles < limit) begin
      @(negedge clk_phy);
      cycles++;
    end
    if (!gt_tx_com_strt_o) begin
      $display("Timeout: no COM start pulse for %s", what);
      errors++;
      finish_run();
    end else begin
      compare(what, exp_ty, gt_tx_com_type_o);
    end
  endtask

  // Receive idle in ready ends the link
  task automatic drop_link();
    @(posedge clk_phy);
    gt_rx_elec_idle_i <= 1'b1;
    wait_cond(1, 20, "link drop on receive idle");
    @(posedge clk_phy);
    gt_rx_elec_idle_i <= 1'b0;
  endtask

  initial begin
    int cyc;
    int d102;
    rst_n = 1'b0;
    gt_rst_done_i = 1'b0;
    gt_rx_elec_idle_i = 1'b0;
    // Outputs checked after each of the first seven reset edges
    repeat (7) begin
      @(posedge clk_phy);
      @(negedge clk_phy);
      compare("reset_link_up", 0, link_up_o);
      compare("reset_tx_data", 0, gt_tx_data_o);
      compare("reset_tx_charisk", 0, gt_tx_charisk_o);
      compare("reset_com_strt", 0, gt_tx_com_strt_o);
      compare("reset_com_type", 0, gt_tx_com_type_o);
      compare("reset_tx_idle", 0, gt_tx_elec_idle_o);
    end
    // Eighth reset edge
    @(posedge clk_phy);
    rst_n <= 1'b1;
    @(posedge clk_phy);
    in_reset = 1'b0;
    @(negedge clk_phy);
    compare("idle_after_reset", 1, gt_tx_elec_idle_o);
    compare("link_after_reset", 0, link_up_o);
    repeat (3 + ($unsigned($random(seed)) % 8)) @(posedge clk_phy);
    gt_rst_done_i <= 1'b1;

    // Full bring-up
    wait_strt("first_com_reset", 40, sata_oob_pkg::COM_RESET, cyc);
    wait_strt("first_com_wake", 200, sata_oob_pkg::COM_WAKE, cyc);
    wait_cond(2, 100, "transmit leaving electrical idle");
    compare("d102_data", `SATA_D102_WORD, gt_tx_data_o);
    wait_cond(3, 100, "ALIGN on transmit");
    compare("align_k", `SATA_K_LANE0, gt_tx_charisk_o);
    wait_cond(0, 100, "link up");
    repeat (10) @(negedge clk_phy);

    // COMINIT suppressed
    no_cominit = 1'b1;
    drop_link();
    wait_strt("cominit_first", 40, sata_oob_pkg::COM_RESET, cyc);
    expect_down = 1'b1;
    wait_strt("cominit_retry", RETRY + 40, sata_oob_pkg::COM_RESET, cyc);
    // Retry cannot come before the full wait has run down
    compare("retry_wait_length", 1, cyc >= RETRY);
    no_cominit = 1'b0;
    expect_down = 1'b0;
    wait_cond(0, 400, "link up after COMINIT retry");

    // ALIGN suppressed
    no_align = 1'b1;
    drop_link();
    wait_strt("align_to_reset", 40, sata_oob_pkg::COM_RESET, cyc);
    wait_strt("align_to_wake", 200, sata_oob_pkg::COM_WAKE, cyc);
    wait_cond(2, 100, "D10.2 during ALIGN wait");
    d102 = 0;
    for (cyc = 0; cyc < ALIGN_WAIT + 40 && !gt_tx_com_strt_o; cyc++) begin
      if (!gt_tx_elec_idle_o) begin
        d102++;
      end
      @(negedge clk_phy);
    end
    no_align = 1'b0;
    if (!gt_tx_com_strt_o) begin
      $display("Timeout: no COM start pulse after the ALIGN wait ran out");
      errors++;
      finish_run();
    end else begin
      compare("align_timeout_type", sata_oob_pkg::COM_RESET, gt_tx_com_type_o);
      compare("align_wait_length", 1, d102 >= ALIGN_WAIT);
    end
    wait_cond(0, 400, "link up after ALIGN timeout");

    // Broken K28.3 run
    break_run = 1'b1;
    drop_link();
    wait_cond(0, 400, "link up after broken K28.3 run");
    break_run = 1'b0;

    // Link loss and a second random bring-up
    repeat (1 + ($unsigned($random(seed)) % 20)) @(posedge clk_phy);
    break_run = (($unsigned($random(seed)) % 2) == 1);
    drop_link();
    wait_strt("relink_com_reset", 40, sata_oob_pkg::COM_RESET, cyc);
    wait_cond(0, 400, "link up after link loss");
    break_run = 1'b0;
    repeat (10) @(negedge clk_phy);
    finish_run();
  end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/sata_oob_pkg.sv
hdl/sata_prim_pkg.sv
hdl/oob_if.sv
hdl/oob_seq.sv
hdl/com_launcher.sv
hdl/oob_timers.sv
hdl/tx_prim_gen.sv
hdl/rx_prim_detect.sv
hdl/sata_phy_host_ctrl.sv
dv/sata_dev_model.sv
dv/sata_phy_host_ctrl_tb.sv
